/* filelist.f */
epu_pkg.sv
epu_buffer_ram.sv
epu_axi_slave.sv
epu_mac_engine.sv
epu_top.sv
tb_epu_top.sv

/* tb_epu_top.sv */
`timescale 1ns/100ps

module tb_epu_top import epu_pkg::*; ();

    localparam int          HS_TIMEOUT  = 200;
    localparam int          RUN_TIMEOUT = 2000;
    localparam logic [31:0] LFSR_POLY   = 32'h8020_0003;
    localparam int          CH_AW = 0;
    localparam int          CH_W  = 1;
    localparam int          CH_B  = 2;
    localparam int          CH_AR = 3;

    logic  clk;
    logic  rst;
    logic  awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic  arvalid, arready, rvalid, rready, rlast, epuint;
    addr_t awaddr, araddr;
    id_t   awid, arid, bid, rid;
    len_t  awlen, arlen;
    data_t wdata, rdata;
    strb_t wstrb;
    resp_t bresp, rresp;

    // Reference state
    data_t in_mem  [BUF_DEPTH];
    data_t w_mem   [BUF_DEPTH];
    data_t out_mem [BUF_DEPTH];
    data_t wr_data [16];
    strb_t wr_strb [16];
    data_t rd_data [16];

    logic [31:0] lfsr;
    id_t         b_id_seen;
    resp_t       b_resp_seen;
    int          errors, checks;
    int          base, k, j, start, len;
    int          run_n [3];
    int          run_m [3];
    buf_sel_t    sel;
    data_t       val;

    epu_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .awaddr_i  (awaddr),
        .awid_i    (awid),
        .awlen_i   (awlen),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wlast_i   (wlast),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .bid_o     (bid),
        .bresp_o   (bresp),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .araddr_i  (araddr),
        .arid_i    (arid),
        .arlen_i   (arlen),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .rdata_o   (rdata),
        .rid_o     (rid),
        .rresp_o   (rresp),
        .rlast_o   (rlast),
        .epuint_o  (epuint)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int b = 0; b < n; b++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
        end
        return bits;
    endfunction

    function automatic data_t apply_strobes(input data_t old_w, input data_t new_w,
                                            input strb_t strb);
        data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic addr_t buffer_base(input buf_sel_t s);
        case (s)
            SEL_IN:  return IN_BASE;
            SEL_OUT: return OUT_BASE;
            default: return WEIGHT_BASE;
        endcase
    endfunction

    function automatic data_t shadow_word(input buf_sel_t s, input int idx);
        case (s)
            SEL_IN:  return in_mem[idx];
            SEL_OUT: return out_mem[idx];
            default: return w_mem[idx];
        endcase
    endfunction

    // Expected output word for one row
    function automatic data_t model_dot(input int n, input int row, input logic relu);
        data_t acc;
        acc = '0;
        for (int i = 0; i < n; i++) begin
            acc = acc + in_mem[i] * w_mem[row * n + i];
        end
        if (relu && $signed(acc) < 0) begin
            acc = '0;
        end
        return acc;
    endfunction

    function automatic logic channel_ready(input int ch);
        case (ch)
            CH_AW:   return awready;
            CH_W:    return wready;
            CH_B:    return bvalid;
            default: return arready;
        endcase
    endfunction

    task automatic report_mismatch(input string sig, input data_t exp, input data_t act);
        $display("Fail %0t %s expected %h got %h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic report_test(input string name, input int err_base);
        $display("Test %s finished with %0d errors", name, errors - err_base);
    endtask

    // Valid is already driven; the transfer happens on the edge after ready is seen
    task automatic handshake(input int ch, input string what);
        int t;
        t = 0;
        @(negedge clk);
        while (!channel_ready(ch) && t < HS_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!channel_ready(ch)) begin
            $display("Timeout at %0t waiting for %s", $time, what);
            errors++;
        end
        b_id_seen   = bid;
        b_resp_seen = bresp;
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write_burst(input addr_t addr, input id_t id, input int n_len,
                                   input resp_t exp_resp);
        int b;
        awvalid = 1'b1;
        awaddr  = addr;
        awid    = id;
        awlen   = len_t'(n_len);
        handshake(CH_AW, "awready");
        awvalid = 1'b0;
        for (b = 0; b <= n_len; b++) begin
            wvalid = 1'b1;
            wdata  = wr_data[b];
            wstrb  = wr_strb[b];
            wlast  = (b == n_len);
            handshake(CH_W, "wready");
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        bready = 1'b1;
        handshake(CH_B, "bvalid");
        bready = 1'b0;
        checks++;
        if (b_id_seen !== id) begin
            report_mismatch("bid", data_t'(id), data_t'(b_id_seen));
        end
        checks++;
        if (b_resp_seen !== exp_resp) begin
            report_mismatch("bresp", data_t'(exp_resp), data_t'(b_resp_seen));
        end
    endtask

    task automatic axi_read_burst(input addr_t addr, input id_t id, input int n_len,
                                  input resp_t exp_resp);
        int beat;
        int t;
        arvalid = 1'b1;
        araddr  = addr;
        arid    = id;
        arlen   = len_t'(n_len);
        handshake(CH_AR, "arready");
        arvalid = 1'b0;
        beat = 0;
        t = 0;
        while (beat <= n_len && t < HS_TIMEOUT) begin
            // Ready low about one cycle in four
            rready = (next_bits(2) != 0);
            @(negedge clk);
            if (rvalid && rready) begin
                rd_data[beat] = rdata;
                checks++;
                if (rid !== id) begin
                    report_mismatch("rid", data_t'(id), data_t'(rid));
                end
                checks++;
                if (rresp !== exp_resp) begin
                    report_mismatch("rresp", data_t'(exp_resp), data_t'(rresp));
                end
                checks++;
                if (rlast !== (beat == n_len)) begin
                    report_mismatch("rlast", data_t'(beat == n_len), data_t'(rlast));
                end
                beat++;
                t = 0;
            end else begin
                t++;
            end
            @(posedge clk);
            #1;
        end
        rready = 1'b0;
        if (beat <= n_len) begin
            $display("Timeout at %0t: read burst stopped after %0d of %0d beats",
                     $time, beat, n_len + 1);
            errors++;
        end
    endtask

    task automatic write_buffer(input buf_sel_t s, input int first, input int n_len,
                                input logic full);
        int b;
        for (b = 0; b <= n_len; b++) begin
            wr_data[b] = next_bits(32);
            wr_strb[b] = full ? 4'hf : strb_t'(next_bits(4));
        end
        axi_write_burst(buffer_base(s) + addr_t'(first * 4), id_t'(next_bits(4)),
                        n_len, RESP_OKAY);
        for (b = 0; b <= n_len; b++) begin
            if (s == SEL_IN) begin
                in_mem[first + b] = apply_strobes(in_mem[first + b], wr_data[b], wr_strb[b]);
            end else begin
                w_mem[first + b] = apply_strobes(w_mem[first + b], wr_data[b], wr_strb[b]);
            end
        end
    endtask

    task automatic check_buffer(input buf_sel_t s, input int first, input int n_len);
        int b;
        axi_read_burst(buffer_base(s) + addr_t'(first * 4), id_t'(next_bits(4)),
                       n_len, RESP_OKAY);
        for (b = 0; b <= n_len; b++) begin
            checks++;
            if (rd_data[b] !== shadow_word(s, first + b)) begin
                report_mismatch("rdata", shadow_word(s, first + b), rd_data[b]);
            end
        end
    endtask

    task automatic write_word(input addr_t addr, input data_t data);
        wr_data[0] = data;
        wr_strb[0] = 4'hf;
        axi_write_burst(addr, id_t'(next_bits(4)), 0, RESP_OKAY);
    endtask

    task automatic check_word(input addr_t addr, input data_t exp, input string name);
        axi_read_burst(addr, id_t'(next_bits(4)), 0, RESP_OKAY);
        checks++;
        if (rd_data[0] !== exp) begin
            report_mismatch(name, exp, rd_data[0]);
        end
    endtask

    task automatic run_engine(input int n, input int m, input logic relu);
        int t;
        int row;
        write_word(CTRL_BASE, {15'd0, relu, cnt_t'(m), cnt_t'(n)});
        write_word(CTRL_BASE + addr_t'(4), 32'd1);
        t = 0;
        @(negedge clk);
        while (!epuint && t < RUN_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!epuint) begin
            $display("Timeout at %0t: interrupt did not rise for N=%0d M=%0d", $time, n, m);
            errors++;
        end
        @(posedge clk);
        #1;
        for (row = 0; row < m; row++) begin
            out_mem[row] = model_dot(n, row, relu);
        end
        check_buffer(SEL_OUT, 0, m - 1);
        check_word(CTRL_BASE + addr_t'(4), 32'd2, "status");
    endtask

    initial begin
        lfsr    = 32'hc284;
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        awid    = '0;
        awlen   = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arid    = '0;
        arlen   = '0;
        rready  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        base = errors;
        check_word(CTRL_BASE + addr_t'(4), 32'd0, "status");
        check_word(CTRL_BASE, 32'd0, "config");
        for (k = 0; k < 4; k++) begin
            val = next_bits(32);
            write_word(CTRL_BASE, val);
            check_word(CTRL_BASE, val & 32'h0001_ffff, "config");
        end
        report_test("control registers", base);

        // Fill the operand area first so partial strobes land on known bytes
        base = errors;
        for (k = 0; k < 8; k++) begin
            write_buffer(SEL_IN, k * 16, 15, 1'b1);
            write_buffer(SEL_WEIGHT, k * 16, 15, 1'b1);
        end
        for (k = 0; k < 24; k++) begin
            sel   = next_bits(1) ? SEL_WEIGHT : SEL_IN;
            len   = int'(next_bits(4));
            start = int'(next_bits(7));
            if (start + len > 127) begin
                start = 127 - len;
            end
            write_buffer(sel, start, len, 1'b0);
            check_buffer(sel, start, len);
        end
        report_test("random bursts", base);

        base = errors;
        for (k = 0; k < 8; k++) begin
            check_buffer(SEL_IN, k * 16, 15);
            check_buffer(SEL_WEIGHT, k * 16, 15);
        end
        report_test("read stalls and IDs", base);

        // Upper byte 0x51 is unmapped but the word index overlaps the input buffer
        base = errors;
        for (k = 0; k < 4; k++) begin
            len = int'(next_bits(4));
            for (j = 0; j <= len; j++) begin
                wr_data[j] = next_bits(32);
                wr_strb[j] = 4'hf;
            end
            axi_write_burst(32'h5100_0000 + addr_t'(k * 64), id_t'(next_bits(4)),
                            len, RESP_SLVERR);
            axi_read_burst(32'h5100_0000 + addr_t'(k * 64), id_t'(next_bits(4)),
                           len, RESP_SLVERR);
            for (j = 0; j <= len; j++) begin
                checks++;
                if (rd_data[j] !== 32'd0) begin
                    report_mismatch("rdata", 32'd0, rd_data[j]);
                end
            end
        end
        for (k = 0; k < 4; k++) begin
            check_buffer(SEL_IN, k * 16, 15);
        end
        report_test("unmapped accesses", base);

        base = errors;
        for (k = 0; k < 3; k++) begin
            run_n[k] = int'(next_bits(5)) % 17;
            run_m[k] = int'(next_bits(3)) + 1;
            run_engine(run_n[k], run_m[k], 1'b0);
        end
        report_test("engine runs", base);

        base = errors;
        for (k = 0; k < 3; k++) begin
            run_engine(run_n[k], run_m[k], 1'b1);
        end
        report_test("ReLU runs", base);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* epu_top.sv */
`timescale 1ns/100ps

module epu_top import epu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  awvalid_i,
    output logic  awready_o,
    input  addr_t awaddr_i,
    input  id_t   awid_i,
    input  len_t  awlen_i,
    input  logic  wvalid_i,
    output logic  wready_o,
    input  data_t wdata_i,
    input  strb_t wstrb_i,
    input  logic  wlast_i,
    output logic  bvalid_o,
    input  logic  bready_i,
    output id_t   bid_o,
    output resp_t bresp_o,
    input  logic  arvalid_i,
    output logic  arready_o,
    input  addr_t araddr_i,
    input  id_t   arid_i,
    input  len_t  arlen_i,
    output logic  rvalid_o,
    input  logic  rready_i,
    output data_t rdata_o,
    output id_t   rid_o,
    output resp_t rresp_o,
    output logic  rlast_o,
    output logic  epuint_o
);

    logic      ram_we;
    strb_t     ram_strb;
    buf_addr_t ram_addr;
    data_t     ram_wdata;
    logic      in_en, weight_en, out_en;
    data_t     in_rdata, weight_rdata, out_rdata;
    logic      start, relu, busy, done;
    cnt_t      n, m;
    buf_addr_t eng_in_addr, eng_w_addr, eng_out_addr;
    logic      eng_in_en, eng_w_en, eng_out_we;
    data_t     eng_in_rdata, eng_w_rdata, eng_out_wdata;

    assign epuint_o = done;

    // AXI ports connect by name
    epu_axi_slave u_slave (
        .ram_we_o       (ram_we),
        .ram_strb_o     (ram_strb),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .in_en_o        (in_en),
        .weight_en_o    (weight_en),
        .out_en_o       (out_en),
        .in_rdata_i     (in_rdata),
        .weight_rdata_i (weight_rdata),
        .out_rdata_i    (out_rdata),
        .start_o        (start),
        .n_o            (n),
        .m_o            (m),
        .relu_o         (relu),
        .busy_i         (busy),
        .done_i         (done),
        .*
    );

    epu_buffer_ram u_in_buf (
        .clk         (clk),
        .bus_en_i    (in_en),
        .bus_we_i    (ram_we),
        .bus_strb_i  (ram_strb),
        .bus_addr_i  (ram_addr),
        .bus_wdata_i (ram_wdata),
        .bus_rdata_o (in_rdata),
        .eng_en_i    (eng_in_en),
        .eng_we_i    (1'b0),
        .eng_addr_i  (eng_in_addr),
        .eng_wdata_i ('0),
        .eng_rdata_o (eng_in_rdata)
    );

    epu_buffer_ram u_weight_buf (
        .clk         (clk),
        .bus_en_i    (weight_en),
        .bus_we_i    (ram_we),
        .bus_strb_i  (ram_strb),
        .bus_addr_i  (ram_addr),
        .bus_wdata_i (ram_wdata),
        .bus_rdata_o (weight_rdata),
        .eng_en_i    (eng_w_en),
        .eng_we_i    (1'b0),
        .eng_addr_i  (eng_w_addr),
        .eng_wdata_i ('0),
        .eng_rdata_o (eng_w_rdata)
    );

    // Engine only writes the output buffer
    epu_buffer_ram u_out_buf (
        .clk         (clk),
        .bus_en_i    (out_en),
        .bus_we_i    (ram_we),
        .bus_strb_i  (ram_strb),
        .bus_addr_i  (ram_addr),
        .bus_wdata_i (ram_wdata),
        .bus_rdata_o (out_rdata),
        .eng_en_i    (eng_out_we),
        .eng_we_i    (eng_out_we),
        .eng_addr_i  (eng_out_addr),
        .eng_wdata_i (eng_out_wdata),
        .eng_rdata_o ()
    );

    epu_mac_engine u_engine (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start),
        .n_i         (n),
        .m_i         (m),
        .relu_i      (relu),
        .busy_o      (busy),
        .done_o      (done),
        .in_addr_o   (eng_in_addr),
        .in_en_o     (eng_in_en),
        .in_rdata_i  (eng_in_rdata),
        .w_addr_o    (eng_w_addr),
        .w_en_o      (eng_w_en),
        .w_rdata_i   (eng_w_rdata),
        .out_we_o    (eng_out_we),
        .out_addr_o  (eng_out_addr),
        .out_wdata_o (eng_out_wdata)
    );

endmodule

/* epu_mac_engine.sv */
`timescale 1ns/100ps

module epu_mac_engine import epu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  cnt_t      n_i,
    input  cnt_t      m_i,
    input  logic      relu_i,
    output logic      busy_o,
    output logic      done_o,
    // Input buffer read
    output buf_addr_t in_addr_o,
    output logic      in_en_o,
    input  data_t     in_rdata_i,
    // Weight buffer read
    output buf_addr_t w_addr_o,
    output logic      w_en_o,
    input  data_t     w_rdata_i,
    // Output buffer write
    output logic      out_we_o,
    output buf_addr_t out_addr_o,
    output data_t     out_wdata_o
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        ACC,
        STORE
    } eng_state_t;

    eng_state_t state_q;

    cnt_t      n_q, m_q;
    cnt_t      i_q, row_q;
    logic      relu_q;
    buf_addr_t w_base_q;
    data_t     acc_q;
    data_t     prod;
    logic      issue;
    logic      busy_q, done_q;

    // One operand pair per cycle while indices remain
    assign issue = ((state_q == FETCH) & (n_q != '0)) | ((state_q == ACC) & (i_q != n_q));

    assign in_addr_o = i_q;
    assign w_addr_o  = w_base_q + i_q;
    assign in_en_o   = issue;
    assign w_en_o    = issue;

    // Truncated to the word width
    assign prod = in_rdata_i * w_rdata_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            n_q      <= '0;
            m_q      <= '0;
            relu_q   <= 1'b0;
            i_q      <= '0;
            row_q    <= '0;
            w_base_q <= '0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        n_q      <= n_i;
                        m_q      <= m_i;
                        relu_q   <= relu_i;
                        i_q      <= '0;
                        row_q    <= '0;
                        w_base_q <= '0;
                        if (m_i == '0) begin
                            done_q <= 1'b1;
                        end else begin
                            done_q  <= 1'b0;
                            busy_q  <= 1'b1;
                            state_q <= FETCH;
                        end
                    end
                end
                FETCH: begin
                    if (n_q == '0) begin
                        state_q <= STORE;
                    end else begin
                        i_q     <= cnt_t'(1);
                        state_q <= ACC;
                    end
                end
                ACC: begin
                    // Data of the last issued pair arrives here
                    if (i_q == n_q) begin
                        state_q <= STORE;
                    end else begin
                        i_q <= i_q + cnt_t'(1);
                    end
                end
                STORE: begin
                    i_q      <= '0;
                    row_q    <= row_q + cnt_t'(1);
                    w_base_q <= w_base_q + n_q;
                    if (row_q == m_q - cnt_t'(1)) begin
                        busy_q  <= 1'b0;
                        done_q  <= 1'b1;
                        state_q <= IDLE;
                    end else begin
                        state_q <= FETCH;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == FETCH) begin
            acc_q <= '0;
        end else if (state_q == ACC) begin
            acc_q <= acc_q + prod;
        end
    end

    assign out_we_o    = state_q == STORE;
    assign out_addr_o  = row_q;
    assign out_wdata_o = (relu_q & acc_q[DATA_W-1]) ? '0 : acc_q;

    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

/* epu_axi_slave.sv */
`timescale 1ns/100ps

module epu_axi_slave import epu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Write address
    input  logic      awvalid_i,
    output logic      awready_o,
    input  addr_t     awaddr_i,
    input  id_t       awid_i,
    input  len_t      awlen_i,
    // Write data
    input  logic      wvalid_i,
    output logic      wready_o,
    input  data_t     wdata_i,
    input  strb_t     wstrb_i,
    input  logic      wlast_i,
    // Write response
    output logic      bvalid_o,
    input  logic      bready_i,
    output id_t       bid_o,
    output resp_t     bresp_o,
    // Read address
    input  logic      arvalid_i,
    output logic      arready_o,
    input  addr_t     araddr_i,
    input  id_t       arid_i,
    input  len_t      arlen_i,
    // Read data
    output logic      rvalid_o,
    input  logic      rready_i,
    output data_t     rdata_o,
    output id_t       rid_o,
    output resp_t     rresp_o,
    output logic      rlast_o,
    // Buffer bus ports
    output logic      ram_we_o,
    output strb_t     ram_strb_o,
    output buf_addr_t ram_addr_o,
    output data_t     ram_wdata_o,
    output logic      in_en_o,
    output logic      weight_en_o,
    output logic      out_en_o,
    input  data_t     in_rdata_i,
    input  data_t     weight_rdata_i,
    input  data_t     out_rdata_i,
    // Engine control
    output logic      start_o,
    output cnt_t      n_o,
    output cnt_t      m_o,
    output logic      relu_o,
    input  logic      busy_i,
    input  logic      done_i
);

    typedef enum logic [1:0] {
        IDLE,
        W_CH,
        B_CH,
        R_CH
    } slv_state_t;

    slv_state_t state_q, state_d;

    logic      awhns, whns, bhns, arhns, rhns;
    logic      active_q;
    logic      r_data_q;
    addr_t     addr_q;
    id_t       id_q;
    len_t      len_q;
    len_t      cnt_q;
    buf_sel_t  sel_q;
    buf_addr_t word_idx;
    logic      ram_en;
    logic      ctrl_wr;
    data_t     ctrl_rdata_q;
    cnt_t      n_q, m_q;
    logic      relu_q, start_q;

    function automatic buf_sel_t decode(addr_t addr);
        case (addr & REGION_MASK)
            IN_BASE:     decode = SEL_IN;
            OUT_BASE:    decode = SEL_OUT;
            WEIGHT_BASE: decode = SEL_WEIGHT;
            CTRL_BASE:   decode = SEL_CTRL;
            default:     decode = SEL_NONE;
        endcase
    endfunction

    assign awhns = awvalid_i & awready_o;
    assign whns  = wvalid_i & wready_o;
    assign bhns  = bvalid_o & bready_i;
    assign arhns = arvalid_i & arready_o;
    assign rhns  = rvalid_o & rready_i;

    // Write address takes priority over read address
    assign awready_o = active_q & (state_q == IDLE);
    assign arready_o = active_q & (state_q == IDLE) & ~awvalid_i;
    assign wready_o  = state_q == W_CH;
    assign bvalid_o  = state_q == B_CH;
    assign rvalid_o  = (state_q == R_CH) & r_data_q;
    assign rlast_o   = rvalid_o & (cnt_q == len_q);
    assign bid_o     = id_q;
    assign rid_o     = id_q;
    assign bresp_o   = (sel_q == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
    assign rresp_o   = (sel_q == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
            state_q  <= IDLE;
        end else begin
            active_q <= 1'b1;
            state_q  <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (awhns) begin
                    state_d = W_CH;
                end else if (arhns) begin
                    state_d = R_CH;
                end
            end
            W_CH:    state_d = (whns & wlast_i) ? B_CH : W_CH;
            B_CH:    state_d = bhns ? IDLE : B_CH;
            R_CH:    state_d = (rhns & rlast_o) ? IDLE : R_CH;
            default: state_d = IDLE;
        endcase
    end

    // Capture the request and step one word per beat
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_q <= '0;
            id_q   <= '0;
            len_q  <= '0;
            cnt_q  <= '0;
            sel_q  <= SEL_NONE;
        end else if (awhns) begin
            addr_q <= awaddr_i;
            id_q   <= awid_i;
            len_q  <= awlen_i;
            cnt_q  <= '0;
            sel_q  <= decode(awaddr_i);
        end else if (arhns) begin
            addr_q <= araddr_i;
            id_q   <= arid_i;
            len_q  <= arlen_i;
            cnt_q  <= '0;
            sel_q  <= decode(araddr_i);
        end else if (whns | rhns) begin
            addr_q <= addr_q + addr_t'(4);
            cnt_q  <= cnt_q + len_t'(1);
        end
    end

    // Read beat alternates address cycle and data cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r_data_q <= 1'b0;
        end else if (state_q == R_CH) begin
            r_data_q <= r_data_q ? ~rhns : 1'b1;
        end else begin
            r_data_q <= 1'b0;
        end
    end

    assign word_idx    = addr_q[BUF_AW+1:2];
    assign ram_en      = whns | ((state_q == R_CH) & ~r_data_q);
    assign ram_we_o    = state_q == W_CH;
    assign ram_strb_o  = wstrb_i;
    assign ram_addr_o  = word_idx;
    assign ram_wdata_o = wdata_i;
    assign in_en_o     = ram_en & (sel_q == SEL_IN);
    assign weight_en_o = ram_en & (sel_q == SEL_WEIGHT);
    assign out_en_o    = ram_en & (sel_q == SEL_OUT);

    always_comb begin
        case (sel_q)
            SEL_IN:     rdata_o = in_rdata_i;
            SEL_OUT:    rdata_o = out_rdata_i;
            SEL_WEIGHT: rdata_o = weight_rdata_i;
            SEL_CTRL:   rdata_o = ctrl_rdata_q;
            default:    rdata_o = '0;
        endcase
    end

    // Control window is frozen while the engine runs
    assign ctrl_wr = whns & (sel_q == SEL_CTRL) & ~busy_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            n_q     <= '0;
            m_q     <= '0;
            relu_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (ctrl_wr) begin
                if (word_idx == CTRL_CFG_IDX) begin
                    n_q    <= wdata_i[7:0];
                    m_q    <= wdata_i[15:8];
                    relu_q <= wdata_i[16];
                end else if (word_idx == CTRL_CMD_IDX) begin
                    start_q <= wdata_i[0];
                end
            end
        end
    end

    // Sampled in the address cycle like a RAM read
    always_ff @(posedge clk) begin
        if ((state_q == R_CH) & ~r_data_q) begin
            case (word_idx)
                CTRL_CFG_IDX: ctrl_rdata_q <= {15'd0, relu_q, m_q, n_q};
                CTRL_CMD_IDX: ctrl_rdata_q <= {30'd0, done_i, busy_i};
                default:      ctrl_rdata_q <= '0;
            endcase
        end
    end

    assign start_o = start_q;
    assign n_o     = n_q;
    assign m_o     = m_q;
    assign relu_o  = relu_q;

endmodule

/* epu_buffer_ram.sv */
`timescale 1ns/100ps

module epu_buffer_ram import epu_pkg::*; (
    input  logic      clk,
    // Bus side
    input  logic      bus_en_i,
    input  logic      bus_we_i,
    input  strb_t     bus_strb_i,
    input  buf_addr_t bus_addr_i,
    input  data_t     bus_wdata_i,
    output data_t     bus_rdata_o,
    // Engine side
    input  logic      eng_en_i,
    input  logic      eng_we_i,
    input  buf_addr_t eng_addr_i,
    input  data_t     eng_wdata_i,
    output data_t     eng_rdata_o
);

    data_t mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (bus_en_i) begin
            if (bus_we_i) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (bus_strb_i[b]) begin
                        mem[bus_addr_i][b*8 +: 8] <= bus_wdata_i[b*8 +: 8];
                    end
                end
            end
            bus_rdata_o <= mem[bus_addr_i];
        end
        // Engine write lands last on an address collision
        if (eng_en_i) begin
            if (eng_we_i) begin
                mem[eng_addr_i] <= eng_wdata_i;
            end
            eng_rdata_o <= mem[eng_addr_i];
        end
    end

endmodule

/* epu_pkg.sv */
package epu_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;
    localparam int BUF_AW = 8;
    localparam int CNT_W  = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [1:0]        resp_t;
    typedef logic [BUF_AW-1:0] buf_addr_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    localparam int BUF_DEPTH = 256;

    // Region bases decoded on the upper address byte
    localparam addr_t IN_BASE     = 32'h5000_0000;
    localparam addr_t OUT_BASE    = 32'h6000_0000;
    localparam addr_t WEIGHT_BASE = 32'h7000_0000;
    localparam addr_t CTRL_BASE   = 32'h8000_0000;
    localparam addr_t REGION_MASK = 32'hff00_0000;

    // Word offsets inside the control window
    localparam buf_addr_t CTRL_CFG_IDX = 8'd0;
    localparam buf_addr_t CTRL_CMD_IDX = 8'd1;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_IN,
        SEL_OUT,
        SEL_WEIGHT,
        SEL_CTRL
    } buf_sel_t;

endpackage
